/* pipe_pkg.sv */
// shared widths, opcodes, ALU codes and stage payloads; every RTL file refers here by scope
`default_nettype none

package pipe_pkg;

    localparam int xlen = 64;

    typedef logic [xlen-1:0] word_t;
    typedef logic [31:0]     inst_t;
    typedef logic [4:0]      reg_addr_t;

    localparam word_t reset_pc = '0;

    // major opcodes of the supported subset
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal    = 7'b1101111;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_pass_b,
        alu_branch_eq,
        alu_branch_ne,
        alu_link
    } alu_op_e;

    typedef struct packed {
        word_t pc;
        inst_t inst;
    } if_id_t;

    // base and offset only matter for branches and jal
    typedef struct packed {
        word_t     pc;
        word_t     op1;
        word_t     op2;
        word_t     base;
        word_t     offset;
        alu_op_e   alu_op;
        reg_addr_t rd;
        logic      rd_wen;
    } id_ex_t;

    // also carried from memory to write-back
    typedef struct packed {
        word_t     pc;
        reg_addr_t rd;
        logic      rd_wen;
        word_t     result;
    } ex_mem_t;

endpackage

`default_nettype wire

/* pc_reg.sv */
// program counter for the fetch stage, stepping by four, loading jump targets and freezing
`timescale 1ns/100ps
`default_nettype none

module pc_reg (
    input  logic            clk,
    input  logic            rst_i,
    input  logic            hold_i,
    input  logic            jump_en_i,
    input  pipe_pkg::word_t jump_addr_i,
    output pipe_pkg::word_t pc_o
);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc_o <= pipe_pkg::reset_pc;
        end else if (!hold_i) begin
            // a resolved jump wins over the sequential step
            if (jump_en_i) begin
                pc_o <= jump_addr_i;
            end else begin
                pc_o <= pc_o + pipe_pkg::word_t'(4);
            end
        end
    end

    // jump targets come from execute, so this checks the whole branch path
    a_pc_aligned: assert property (@(posedge clk) disable iff (rst_i) pc_o[1:0] == 2'b00);

endmodule

`default_nettype wire

/* pipe_reg.sv */
// stage register with a valid bit; one instance sits between each pair of pipeline stages
`timescale 1ns/100ps
`default_nettype none

module pipe_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     rst_i,
    input  logic     hold_i,
    input  logic     flush_i,
    input  logic     valid_i,
    input  payload_t data_i,
    output logic     valid_o,
    output payload_t data_o
);

    // hold beats flush, so a squash waits until the freeze ends
    always_ff @(posedge clk) begin
        if (rst_i || (flush_i && !hold_i)) begin
            valid_o <= 1'b0;
            // an empty slot carries no write enable downstream
            data_o  <= '0;
        end else if (!hold_i) begin
            valid_o <= valid_i;
            data_o  <= data_i;
        end
    end

    // ctrl keeps the two requests apart for every stage
    a_no_hold_flush: assert property (@(posedge clk) disable iff (rst_i) !(hold_i && flush_i));

endmodule

`default_nettype wire

/* id.sv */
// decode stage, turning one fetched instruction into operands and an ALU operation for execute
`timescale 1ns/100ps
`default_nettype none

module id (
    input  pipe_pkg::if_id_t    if_id_i,
    output pipe_pkg::reg_addr_t rs1_addr_o,
    output pipe_pkg::reg_addr_t rs2_addr_o,
    input  pipe_pkg::word_t     rs1_data_i,
    input  pipe_pkg::word_t     rs2_data_i,
    output pipe_pkg::id_ex_t    id_ex_o
);

    pipe_pkg::inst_t inst;
    pipe_pkg::word_t imm_i;
    pipe_pkg::word_t imm_u;
    pipe_pkg::word_t imm_b;
    pipe_pkg::word_t imm_j;
    logic [2:0]      funct3;
    logic [6:0]      funct7;

    assign inst   = if_id_i.inst;
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    assign rs1_addr_o = inst[19:15];
    assign rs2_addr_o = inst[24:20];

    // sign-extended immediates of the four formats in use
    assign imm_i = {{52{inst[31]}}, inst[31:20]};
    assign imm_u = {{32{inst[31]}}, inst[31:12], 12'b0};
    assign imm_b = {{52{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_j = {{44{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        id_ex_o        = '0;
        id_ex_o.pc     = if_id_i.pc;
        id_ex_o.rd     = inst[11:7];
        id_ex_o.alu_op = pipe_pkg::alu_add;
        case (inst[6:0])
            pipe_pkg::op_imm: begin
                id_ex_o.op1    = rs1_data_i;
                id_ex_o.op2    = imm_i;
                id_ex_o.rd_wen = 1'b1;
                case (funct3)
                    3'b000: id_ex_o.alu_op = pipe_pkg::alu_add;
                    3'b100: id_ex_o.alu_op = pipe_pkg::alu_xor;
                    3'b110: id_ex_o.alu_op = pipe_pkg::alu_or;
                    3'b111: id_ex_o.alu_op = pipe_pkg::alu_and;
                    default: id_ex_o.rd_wen = 1'b0;
                endcase
            end
            pipe_pkg::op_reg: begin
                id_ex_o.op1    = rs1_data_i;
                id_ex_o.op2    = rs2_data_i;
                id_ex_o.rd_wen = 1'b1;
                case ({funct7, funct3})
                    10'b0000000_000: id_ex_o.alu_op = pipe_pkg::alu_add;
                    10'b0100000_000: id_ex_o.alu_op = pipe_pkg::alu_sub;
                    10'b0000000_100: id_ex_o.alu_op = pipe_pkg::alu_xor;
                    10'b0000000_110: id_ex_o.alu_op = pipe_pkg::alu_or;
                    10'b0000000_111: id_ex_o.alu_op = pipe_pkg::alu_and;
                    10'b0000000_010: id_ex_o.alu_op = pipe_pkg::alu_slt;
                    default: id_ex_o.rd_wen = 1'b0;
                endcase
            end
            pipe_pkg::op_lui: begin
                id_ex_o.op2    = imm_u;
                id_ex_o.alu_op = pipe_pkg::alu_pass_b;
                id_ex_o.rd_wen = 1'b1;
            end
            pipe_pkg::op_branch: begin
                id_ex_o.op1    = rs1_data_i;
                id_ex_o.op2    = rs2_data_i;
                id_ex_o.base   = if_id_i.pc;
                id_ex_o.offset = imm_b;
                // other compare kinds fall through as a plain no-op
                if (funct3 == 3'b000) begin
                    id_ex_o.alu_op = pipe_pkg::alu_branch_eq;
                end else if (funct3 == 3'b001) begin
                    id_ex_o.alu_op = pipe_pkg::alu_branch_ne;
                end
            end
            pipe_pkg::op_jal: begin
                id_ex_o.base   = if_id_i.pc;
                id_ex_o.offset = imm_j;
                id_ex_o.alu_op = pipe_pkg::alu_link;
                id_ex_o.rd_wen = 1'b1;
            end
            default: id_ex_o.rd_wen = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

/* regs.sv */
// integer register file with two combinational read ports and one write port from write-back
`timescale 1ns/100ps
`default_nettype none

module regs (
    input  logic                clk,
    input  logic                rst_i,
    input  pipe_pkg::reg_addr_t rs1_raddr_i,
    input  pipe_pkg::reg_addr_t rs2_raddr_i,
    output pipe_pkg::word_t     rs1_rdata_o,
    output pipe_pkg::word_t     rs2_rdata_o,
    input  pipe_pkg::reg_addr_t waddr_i,
    input  pipe_pkg::word_t     wdata_i,
    input  logic                wen_i
);

    // x0 has no storage
    pipe_pkg::word_t rf [1:31];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 1; i < 32; i++) begin
                rf[i] <= '0;
            end
        end else if (wen_i && (waddr_i != '0)) begin
            rf[waddr_i] <= wdata_i;
        end
    end

    // same-cycle write is picked up by forwarding, not here
    assign rs1_rdata_o = (rs1_raddr_i == '0) ? '0 : rf[rs1_raddr_i];
    assign rs2_rdata_o = (rs2_raddr_i == '0) ? '0 : rf[rs2_raddr_i];

endmodule

`default_nettype wire

/* redirect.sv */
// operand forwarding for decode, taking results from execute, memory and write-back first
`timescale 1ns/100ps
`default_nettype none

module redirect (
    input  pipe_pkg::reg_addr_t rs1_addr_i,
    input  pipe_pkg::reg_addr_t rs2_addr_i,
    output pipe_pkg::reg_addr_t rs1_raddr_o,
    output pipe_pkg::reg_addr_t rs2_raddr_o,
    input  pipe_pkg::word_t     rs1_rdata_i,
    input  pipe_pkg::word_t     rs2_rdata_i,
    input  pipe_pkg::reg_addr_t ex_rd_i,
    input  pipe_pkg::reg_addr_t mem_rd_i,
    input  pipe_pkg::reg_addr_t wb_rd_i,
    input  logic                ex_wen_i,
    input  logic                mem_wen_i,
    input  logic                wb_wen_i,
    input  pipe_pkg::word_t     ex_data_i,
    input  pipe_pkg::word_t     mem_data_i,
    input  pipe_pkg::word_t     wb_data_i,
    output pipe_pkg::word_t     rs1_data_o,
    output pipe_pkg::word_t     rs2_data_o
);

    // youngest writer first, x0 never forwarded
    function automatic pipe_pkg::word_t pick(input pipe_pkg::reg_addr_t rs,
                                             input pipe_pkg::word_t rf_val);
        if (rs == '0) begin
            return rf_val;
        end else if (ex_wen_i && (ex_rd_i == rs)) begin
            return ex_data_i;
        end else if (mem_wen_i && (mem_rd_i == rs)) begin
            return mem_data_i;
        end else if (wb_wen_i && (wb_rd_i == rs)) begin
            return wb_data_i;
        end
        return rf_val;
    endfunction

    assign rs1_raddr_o = rs1_addr_i;
    assign rs2_raddr_o = rs2_addr_i;

    always_comb begin
        rs1_data_o = pick(rs1_addr_i, rs1_rdata_i);
        rs2_data_o = pick(rs2_addr_i, rs2_rdata_i);
    end

endmodule

`default_nettype wire

/* ex.sv */
// execute stage with the ALU, the branch compare and the jump target adder
`timescale 1ns/100ps
`default_nettype none

module ex (
    input  pipe_pkg::id_ex_t  id_ex_i,
    input  logic              valid_i,
    output pipe_pkg::ex_mem_t ex_mem_o,
    output logic              rd_wen_o,
    output logic              jump_en_o,
    output pipe_pkg::word_t   jump_addr_o
);

    pipe_pkg::word_t result;
    logic            taken;
    logic            lt;

    assign lt = $signed(id_ex_i.op1) < $signed(id_ex_i.op2);

    always_comb begin
        result = '0;
        taken  = 1'b0;
        case (id_ex_i.alu_op)
            pipe_pkg::alu_add:       result = id_ex_i.op1 + id_ex_i.op2;
            pipe_pkg::alu_sub:       result = id_ex_i.op1 - id_ex_i.op2;
            pipe_pkg::alu_and:       result = id_ex_i.op1 & id_ex_i.op2;
            pipe_pkg::alu_or:        result = id_ex_i.op1 | id_ex_i.op2;
            pipe_pkg::alu_xor:       result = id_ex_i.op1 ^ id_ex_i.op2;
            pipe_pkg::alu_slt:       result = pipe_pkg::word_t'(lt);
            pipe_pkg::alu_pass_b:    result = id_ex_i.op2;
            pipe_pkg::alu_branch_eq: taken = (id_ex_i.op1 == id_ex_i.op2);
            pipe_pkg::alu_branch_ne: taken = (id_ex_i.op1 != id_ex_i.op2);
            pipe_pkg::alu_link: begin
                // link value is the return address
                result = id_ex_i.pc + pipe_pkg::word_t'(4);
                taken  = 1'b1;
            end
            default: result = '0;
        endcase
    end

    // bubbles must neither write nor redirect
    assign rd_wen_o    = valid_i && id_ex_i.rd_wen;
    assign jump_en_o   = valid_i && taken;
    assign jump_addr_o = id_ex_i.base + id_ex_i.offset;

    assign ex_mem_o = '{
        pc:     id_ex_i.pc,
        rd:     id_ex_i.rd,
        rd_wen: rd_wen_o,
        result: result
    };

endmodule

`default_nettype wire

/* ctrl.sv */
// hazard control, mapping the execute jump and the fetch freeze onto per-stage hold and flush
`timescale 1ns/100ps
`default_nettype none

module ctrl (
    input  logic jump_en_i,
    input  logic fetch_busy_i,
    output logic pc_hold_o,
    output logic pc_jump_o,
    output logic if_id_hold_o,
    output logic if_id_flush_o,
    output logic id_ex_hold_o,
    output logic id_ex_flush_o,
    output logic ex_mem_hold_o,
    output logic mem_wb_hold_o,
    output logic mem_wb_flush_o
);

    logic redirect_now;

    // a jump seen under the freeze resolves again afterwards
    assign redirect_now = jump_en_i && !fetch_busy_i;

    assign pc_hold_o     = fetch_busy_i;
    assign pc_jump_o     = redirect_now;
    assign if_id_hold_o  = fetch_busy_i;
    assign if_id_flush_o = redirect_now;
    assign id_ex_hold_o  = fetch_busy_i;
    assign id_ex_flush_o = redirect_now;
    assign ex_mem_hold_o = fetch_busy_i;

    // write-back drains into a bubble so the retiring slot is reported once
    assign mem_wb_hold_o  = 1'b0;
    assign mem_wb_flush_o = fetch_busy_i;

endmodule

`default_nettype wire

/* core.sv */
// top of the five-stage RV64I subset pipeline; the testbench drives it as the DUT
`timescale 1ns/100ps
`default_nettype none

module core (
    input  logic                clk,
    input  logic                rst_i,
    output pipe_pkg::word_t     imem_addr_o,
    input  pipe_pkg::inst_t     imem_inst_i,
    input  logic                fetch_busy_i,
    output logic                wb_valid_o,
    output pipe_pkg::word_t     wb_pc_o,
    output pipe_pkg::reg_addr_t wb_rd_o,
    output logic                wb_wen_o,
    output pipe_pkg::word_t     wb_data_o
);

    // fetch and decode
    pipe_pkg::if_id_t    if_id_q;
    logic                if_id_v;
    pipe_pkg::reg_addr_t id_rs1_addr;
    pipe_pkg::reg_addr_t id_rs2_addr;
    pipe_pkg::word_t     fwd_rs1_data;
    pipe_pkg::word_t     fwd_rs2_data;
    pipe_pkg::reg_addr_t rf_rs1_addr;
    pipe_pkg::reg_addr_t rf_rs2_addr;
    pipe_pkg::word_t     rf_rs1_data;
    pipe_pkg::word_t     rf_rs2_data;
    pipe_pkg::id_ex_t    id_ex_d;
    // execute, memory, write-back
    pipe_pkg::id_ex_t    id_ex_q;
    logic                id_ex_v;
    pipe_pkg::ex_mem_t   ex_mem_d;
    logic                ex_rd_wen;
    logic                jump_en;
    pipe_pkg::word_t     jump_addr;
    pipe_pkg::ex_mem_t   ex_mem_q;
    logic                ex_mem_v;
    pipe_pkg::ex_mem_t   mem_wb_q;
    logic                mem_wb_v;
    // ctrl outputs
    logic pc_hold;
    logic pc_jump;
    logic if_id_hold;
    logic if_id_flush;
    logic id_ex_hold;
    logic id_ex_flush;
    logic ex_mem_hold;
    logic mem_wb_hold;
    logic mem_wb_flush;

    pc_reg pc_reg_inst (
        .clk         ( clk         ),
        .rst_i       ( rst_i       ),
        .hold_i      ( pc_hold     ),
        .jump_en_i   ( pc_jump     ),
        .jump_addr_i ( jump_addr   ),
        .pc_o        ( imem_addr_o )
    );

    // fetch is combinational, so every fetched word is valid
    pipe_reg #(.payload_t(pipe_pkg::if_id_t)) if_id_reg (
        .clk     ( clk                        ),
        .rst_i   ( rst_i                      ),
        .hold_i  ( if_id_hold                 ),
        .flush_i ( if_id_flush                ),
        .valid_i ( 1'b1                       ),
        .data_i  ( {imem_addr_o, imem_inst_i} ),
        .valid_o ( if_id_v                    ),
        .data_o  ( if_id_q                    )
    );

    id id_inst (
        .if_id_i    ( if_id_q      ),
        .rs1_addr_o ( id_rs1_addr  ),
        .rs2_addr_o ( id_rs2_addr  ),
        .rs1_data_i ( fwd_rs1_data ),
        .rs2_data_i ( fwd_rs2_data ),
        .id_ex_o    ( id_ex_d      )
    );

    regs regs_inst (
        .clk         ( clk             ),
        .rst_i       ( rst_i           ),
        .rs1_raddr_i ( rf_rs1_addr     ),
        .rs2_raddr_i ( rf_rs2_addr     ),
        .rs1_rdata_o ( rf_rs1_data     ),
        .rs2_rdata_o ( rf_rs2_data     ),
        .waddr_i     ( mem_wb_q.rd     ),
        .wdata_i     ( mem_wb_q.result ),
        .wen_i       ( mem_wb_q.rd_wen )
    );

    redirect redirect_inst (
        .rs1_addr_i  ( id_rs1_addr     ),
        .rs2_addr_i  ( id_rs2_addr     ),
        .rs1_raddr_o ( rf_rs1_addr     ),
        .rs2_raddr_o ( rf_rs2_addr     ),
        .rs1_rdata_i ( rf_rs1_data     ),
        .rs2_rdata_i ( rf_rs2_data     ),
        .ex_rd_i     ( ex_mem_d.rd     ),
        .mem_rd_i    ( ex_mem_q.rd     ),
        .wb_rd_i     ( mem_wb_q.rd     ),
        .ex_wen_i    ( ex_rd_wen       ),
        .mem_wen_i   ( ex_mem_q.rd_wen ),
        .wb_wen_i    ( mem_wb_q.rd_wen ),
        .ex_data_i   ( ex_mem_d.result ),
        .mem_data_i  ( ex_mem_q.result ),
        .wb_data_i   ( mem_wb_q.result ),
        .rs1_data_o  ( fwd_rs1_data    ),
        .rs2_data_o  ( fwd_rs2_data    )
    );

    pipe_reg #(.payload_t(pipe_pkg::id_ex_t)) id_ex_reg (
        .clk     ( clk         ),
        .rst_i   ( rst_i       ),
        .hold_i  ( id_ex_hold  ),
        .flush_i ( id_ex_flush ),
        .valid_i ( if_id_v     ),
        .data_i  ( id_ex_d     ),
        .valid_o ( id_ex_v     ),
        .data_o  ( id_ex_q     )
    );

    ex ex_inst (
        .id_ex_i     ( id_ex_q   ),
        .valid_i     ( id_ex_v   ),
        .ex_mem_o    ( ex_mem_d  ),
        .rd_wen_o    ( ex_rd_wen ),
        .jump_en_o   ( jump_en   ),
        .jump_addr_o ( jump_addr )
    );

    ctrl ctrl_inst (
        .jump_en_i      ( jump_en      ),
        .fetch_busy_i   ( fetch_busy_i ),
        .pc_hold_o      ( pc_hold      ),
        .pc_jump_o      ( pc_jump      ),
        .if_id_hold_o   ( if_id_hold   ),
        .if_id_flush_o  ( if_id_flush  ),
        .id_ex_hold_o   ( id_ex_hold   ),
        .id_ex_flush_o  ( id_ex_flush  ),
        .ex_mem_hold_o  ( ex_mem_hold  ),
        .mem_wb_hold_o  ( mem_wb_hold  ),
        .mem_wb_flush_o ( mem_wb_flush )
    );

    // memory stage has no work of its own in this subset
    pipe_reg #(.payload_t(pipe_pkg::ex_mem_t)) ex_mem_reg (
        .clk     ( clk         ),
        .rst_i   ( rst_i       ),
        .hold_i  ( ex_mem_hold ),
        .flush_i ( 1'b0        ),
        .valid_i ( id_ex_v     ),
        .data_i  ( ex_mem_d    ),
        .valid_o ( ex_mem_v    ),
        .data_o  ( ex_mem_q    )
    );

    pipe_reg #(.payload_t(pipe_pkg::ex_mem_t)) mem_wb_reg (
        .clk     ( clk          ),
        .rst_i   ( rst_i        ),
        .hold_i  ( mem_wb_hold  ),
        .flush_i ( mem_wb_flush ),
        .valid_i ( ex_mem_v     ),
        .data_i  ( ex_mem_q     ),
        .valid_o ( mem_wb_v     ),
        .data_o  ( mem_wb_q     )
    );

    // retire port
    assign wb_valid_o = mem_wb_v;
    assign wb_pc_o    = mem_wb_q.pc;
    assign wb_rd_o    = mem_wb_q.rd;
    assign wb_wen_o   = mem_wb_q.rd_wen;
    assign wb_data_o  = mem_wb_q.result;

endmodule

`default_nettype wire

/* tb_iss.svh */
// golden model of the test program, included in the testbench module to fill the expected queue
`ifndef tb_iss_svh
`define tb_iss_svh

// walks the program from reset in architectural order
task automatic build_expected();
    pipe_pkg::word_t rf [32];
    pipe_pkg::word_t pc;
    pipe_pkg::word_t a;
    pipe_pkg::word_t b;
    pipe_pkg::word_t next_pc;
    longint          imm;
    int              idx;
    retire_t         r;

    foreach (rf[i]) begin
        rf[i] = '0;
    end
    pc = pipe_pkg::reset_pc;
    while (pc < end_pc) begin
        idx     = int'(pc >> 2);
        a       = rf[prog_rs1[idx]];
        b       = rf[prog_rs2[idx]];
        imm     = prog_imm[idx];
        next_pc = pc + 4;
        r.pc    = pc;
        r.rd    = prog_rd[idx];
        r.wen   = 1'b1;
        r.data  = '0;
        case (prog_kind[idx])
            ins_addi: r.data = a + imm;
            ins_andi: r.data = a & imm;
            ins_ori:  r.data = a | imm;
            ins_xori: r.data = a ^ imm;
            // upper immediate, sign extended from bit 31
            ins_lui:  r.data = imm << 12;
            ins_add:  r.data = a + b;
            ins_sub:  r.data = a - b;
            ins_and:  r.data = a & b;
            ins_or:   r.data = a | b;
            ins_xor:  r.data = a ^ b;
            ins_slt:  r.data = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            ins_beq: begin
                r.wen = 1'b0;
                if (a == b) begin
                    next_pc = pc + imm;
                end
            end
            ins_bne: begin
                r.wen = 1'b0;
                if (a != b) begin
                    next_pc = pc + imm;
                end
            end
            ins_jal: begin
                r.data  = pc + 4;
                next_pc = pc + imm;
            end
            default: r.wen = 1'b0;
        endcase
        exp_q.push_back(r);
        // x0 stays zero whatever the retire port shows
        if (r.wen && (r.rd != 5'd0)) begin
            rf[r.rd] = r.data;
        end
        pc = next_pc;
    end
    // filler nop at the end address closes the run
    r.pc   = end_pc;
    r.rd   = 5'd0;
    r.wen  = 1'b1;
    r.data = '0;
    exp_q.push_back(r);
endtask

`endif

/* tb_core.sv */
// testbench for core that runs a random program under random fetch stalls and checks the retire port
`timescale 1ns/100ps
`default_nettype none

module tb_core;

    localparam int prog_len = 200;
    localparam pipe_pkg::word_t end_pc = pipe_pkg::word_t'(prog_len * 4);
    // addi x0, x0, 0 fills every address past the program
    localparam pipe_pkg::inst_t nop_inst = 32'h0000_0013;

    typedef enum int {
        ins_addi, ins_andi, ins_ori, ins_xori, ins_lui,
        ins_add, ins_sub, ins_and, ins_or, ins_xor, ins_slt,
        ins_beq, ins_bne, ins_jal
    } kind_e;

    typedef struct packed {
        pipe_pkg::word_t     pc;
        pipe_pkg::reg_addr_t rd;
        logic                wen;
        pipe_pkg::word_t     data;
    } retire_t;

    logic                clk;
    logic                rst_i;
    pipe_pkg::word_t     imem_addr;
    pipe_pkg::inst_t     imem_inst;
    logic                fetch_busy;
    logic                wb_valid;
    pipe_pkg::word_t     wb_pc;
    pipe_pkg::reg_addr_t wb_rd;
    logic                wb_wen;
    pipe_pkg::word_t     wb_data;

    // program as generated, before encoding
    kind_e               prog_kind [prog_len];
    pipe_pkg::reg_addr_t prog_rd [prog_len];
    pipe_pkg::reg_addr_t prog_rs1 [prog_len];
    pipe_pkg::reg_addr_t prog_rs2 [prog_len];
    int                  prog_imm [prog_len];
    pipe_pkg::inst_t     imem [prog_len];
    retire_t             exp_q [$];

    integer seed;
    int     cycles;
    int     busy_cycles;
    int     free_edges;
    int     retired;
    logic   busy_seen;
    logic   done;

    `include "tb_iss.svh"

    core dut0 (
        .clk          ( clk        ),
        .rst_i        ( rst_i      ),
        .imem_addr_o  ( imem_addr  ),
        .imem_inst_i  ( imem_inst  ),
        .fetch_busy_i ( fetch_busy ),
        .wb_valid_o   ( wb_valid   ),
        .wb_pc_o      ( wb_pc      ),
        .wb_rd_o      ( wb_rd      ),
        .wb_wen_o     ( wb_wen     ),
        .wb_data_o    ( wb_data    )
    );

    // combinational instruction memory
    assign imem_inst = (imem_addr < end_pc) ? imem[imem_addr >> 2] : nop_inst;

    always #2 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input pipe_pkg::word_t exp,
                              input pipe_pkg::word_t act);
        if (exp !== act) begin
            abort_run($sformatf("[FAIL] %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_reg(input string name, input pipe_pkg::reg_addr_t exp,
                             input pipe_pkg::reg_addr_t act);
        if (exp !== act) begin
            abort_run($sformatf("[FAIL] %s: expected x%0d, actual x%0d", name, exp, act));
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            abort_run($sformatf("[FAIL] %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    // x0 to x7 only, so neighbours depend on each other often
    function automatic pipe_pkg::reg_addr_t random_reg();
        return pipe_pkg::reg_addr_t'($unsigned($random(seed)) % 8);
    endfunction

    function automatic pipe_pkg::inst_t encode_inst(input int i);
        logic [31:0] imm;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;

        imm = prog_imm[i];
        rd  = prog_rd[i];
        rs1 = prog_rs1[i];
        rs2 = prog_rs2[i];
        case (prog_kind[i])
            ins_addi: return {imm[11:0], rs1, 3'b000, rd, 7'b0010011};
            ins_xori: return {imm[11:0], rs1, 3'b100, rd, 7'b0010011};
            ins_ori:  return {imm[11:0], rs1, 3'b110, rd, 7'b0010011};
            ins_andi: return {imm[11:0], rs1, 3'b111, rd, 7'b0010011};
            ins_lui:  return {imm[19:0], rd, 7'b0110111};
            ins_add:  return {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
            ins_sub:  return {7'b0100000, rs2, rs1, 3'b000, rd, 7'b0110011};
            ins_xor:  return {7'b0000000, rs2, rs1, 3'b100, rd, 7'b0110011};
            ins_or:   return {7'b0000000, rs2, rs1, 3'b110, rd, 7'b0110011};
            ins_and:  return {7'b0000000, rs2, rs1, 3'b111, rd, 7'b0110011};
            ins_slt:  return {7'b0000000, rs2, rs1, 3'b010, rd, 7'b0110011};
            ins_beq:  return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], 7'b1100011};
            ins_bne:  return {imm[12], imm[10:5], rs2, rs1, 3'b001, imm[4:1], imm[11], 7'b1100011};
            ins_jal:  return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
            default:  return nop_inst;
        endcase
    endfunction

    task automatic build_program();
        int sel;
        int room;
        int steps;

        for (int i = 0; i < prog_len; i++) begin
            sel          = $unsigned($random(seed)) % 14;
            prog_kind[i] = kind_e'(sel);
            prog_rd[i]   = random_reg();
            prog_rs1[i]  = random_reg();
            prog_rs2[i]  = random_reg();
            prog_imm[i]  = $random(seed) % 2048;
            if (prog_kind[i] == ins_lui) begin
                prog_imm[i] = $random(seed) % 524288;
            end else if ((prog_kind[i] == ins_beq) || (prog_kind[i] == ins_bne) ||
                         (prog_kind[i] == ins_jal)) begin
                // forward by 1 to 4 words, never past the end address
                room  = prog_len - i;
                steps = 1 + $unsigned($random(seed)) % 4;
                if (steps > room) begin
                    steps = room;
                end
                prog_imm[i] = steps * 4;
            end
            imem[i] = encode_inst(i);
        end
    endtask

    task automatic check_retire();
        retire_t e;

        if (busy_seen) begin
            check_bit("wb_valid_o after a frozen edge", 1'b0, wb_valid);
        end
        // first fetch needs four unfrozen edges to reach write-back
        if (retired == 0) begin
            check_bit("first retire timing", free_edges >= 4, wb_valid);
        end
        if (wb_valid === 1'b1) begin
            e = exp_q.pop_front();
            if (retired == 0) begin
                check_word("first retired pc", pipe_pkg::reset_pc, wb_pc);
            end
            check_word($sformatf("retire %0d pc", retired), e.pc, wb_pc);
            check_bit($sformatf("retire %0d wen", retired), e.wen, wb_wen);
            if (e.wen) begin
                check_reg($sformatf("retire %0d rd", retired), e.rd, wb_rd);
                check_word($sformatf("retire %0d data", retired), e.data, wb_data);
            end
            retired++;
            done = (e.pc == end_pc);
        end else if (wb_valid !== 1'b0) begin
            abort_run("wb_valid_o is unknown on the retire port");
        end
    endtask

    initial begin
        seed        = 32'h238f;
        clk         = 1'b0;
        rst_i       = 1'b1;
        fetch_busy  = 1'b0;
        cycles      = 0;
        busy_cycles = 0;
        free_edges  = 0;
        retired     = 0;
        busy_seen   = 1'b0;
        done        = 1'b0;
        build_program();
        build_expected();

        repeat (8) @(posedge clk);
        #1;
        rst_i = 1'b0;
        check_bit("wb_valid_o after reset", 1'b0, wb_valid);

        while (!done) begin
            @(posedge clk);
            // value the DUT just sampled on this edge
            busy_seen = fetch_busy;
            if (!busy_seen) begin
                free_edges++;
            end
            cycles++;
            #1;
            fetch_busy = (($unsigned($random(seed)) % 5) == 0);
            if (fetch_busy) begin
                busy_cycles++;
            end
            @(negedge clk);
            check_retire();
            if (!done && (cycles >= 4 * prog_len + busy_cycles + 100)) begin
                abort_run($sformatf("timeout: program end not retired after %0d cycles",
                                    cycles));
            end
        end

        $display("retired %0d instructions, %0d frozen cycles", retired, busy_cycles);
        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+.
pipe_pkg.sv
pc_reg.sv
pipe_reg.sv
id.sv
regs.sv
redirect.sv
ex.sv
ctrl.sv
core.sv
tb_core.sv

/* Bender.yml */
package:
  name: rv64i_pipe

sources:
  - files:
      - pipe_pkg.sv
      - pc_reg.sv
      - pipe_reg.sv
      - id.sv
      - regs.sv
      - redirect.sv
      - ex.sv
      - ctrl.sv
      - core.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_core.sv
